// ==== cplx_pkg.sv ====
// complex lane package
// shared widths, opcode encodings, flag bit positions and per-opcode
// flag words, plus the multiplier double-word type
`default_nettype none

package cplx_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int SIZE_DATA   = 32;  // operand and result word
  localparam int SIZE_OPCODE = 8;   // issued opcode
  localparam int SIZE_TAG    = 7;   // destination physical register tag
  localparam int SIZE_FLAGS  = 6;   // execution flag word

  // ========================================
  // opcodes
  // ========================================
  localparam logic [SIZE_OPCODE-1:0] MULT_L  = 8'h30;  // signed product, low word
  localparam logic [SIZE_OPCODE-1:0] MULT_H  = 8'h31;  // signed product, high word
  localparam logic [SIZE_OPCODE-1:0] MULTU_L = 8'h32;  // unsigned product, low word
  localparam logic [SIZE_OPCODE-1:0] MULTU_H = 8'h33;  // unsigned product, high word
  localparam logic [SIZE_OPCODE-1:0] DIV_L   = 8'h34;  // signed quotient
  localparam logic [SIZE_OPCODE-1:0] DIV_H   = 8'h35;  // signed remainder
  localparam logic [SIZE_OPCODE-1:0] DIVU_L  = 8'h36;  // unsigned quotient
  localparam logic [SIZE_OPCODE-1:0] DIVU_H  = 8'h37;  // unsigned remainder
  localparam logic [SIZE_OPCODE-1:0] SYSCALL = 8'h0c;  // trap to the kernel

  // ========================================
  // flag bit positions
  // ========================================
  localparam int FLG_MISPREDICT = 0;
  localparam int FLG_EXCEPTION  = 1;
  localparam int FLG_EXECUTED   = 2;
  localparam int FLG_LOW_HALF   = 3;
  localparam int FLG_DEST_VALID = 4;
  localparam int FLG_BRANCH     = 5;

  // flag words per opcode class
  localparam logic [SIZE_FLAGS-1:0] FLAGS_MD_LO =   // low-half mul/div
    (SIZE_FLAGS'(1) << FLG_DEST_VALID) | (SIZE_FLAGS'(1) << FLG_LOW_HALF) |
    (SIZE_FLAGS'(1) << FLG_EXECUTED);
  localparam logic [SIZE_FLAGS-1:0] FLAGS_MD_HI =   // high-half mul/div
    (SIZE_FLAGS'(1) << FLG_DEST_VALID) | (SIZE_FLAGS'(1) << FLG_EXECUTED);
  localparam logic [SIZE_FLAGS-1:0] FLAGS_SYSCALL =
    (SIZE_FLAGS'(1) << FLG_EXECUTED) | (SIZE_FLAGS'(1) << FLG_EXCEPTION);

  // ========================================
  // multiplier double word
  // ========================================
  typedef struct packed {
    logic [SIZE_DATA-1:0] hi;  // upper word of the product
    logic [SIZE_DATA-1:0] lo;  // lower word of the product
  } prod_halves_t;

  // same 64 bits seen as one number or as two words
  typedef union packed {
    logic [2*SIZE_DATA-1:0] full;  // written by the multiplier
    prod_halves_t           half;  // read by the alu half select
  } prod_word_t;

endpackage

`default_nettype wire

// ==== cplx_issue_reg.sv ====
// complex lane issue register
// captures the issued instruction; strobe every edge, payload only
// when a valid instruction arrives
`timescale 1ns/10ps
`default_nettype none

module cplx_issue_reg (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]    tag_i,
  input  logic [cplx_pkg::SIZE_OPCODE-1:0] opcode_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data1_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data2_i,
  output logic                             valid_o,
  output logic [cplx_pkg::SIZE_TAG-1:0]    tag_o,
  output logic [cplx_pkg::SIZE_OPCODE-1:0] opcode_o,
  output logic [cplx_pkg::SIZE_DATA-1:0]   data1_o,
  output logic [cplx_pkg::SIZE_DATA-1:0]   data2_o
);

  // strobe, cleared by reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;               // empty slot after reset
    end else begin
      valid_o <= valid_i;            // one cycle behind the issue strobe
    end
  end

  // payload, loads only on a real instruction
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      tag_o    <= tag_i;             // destination tag
      opcode_o <= opcode_i;          // operation to perform
      data1_o  <= data1_i;           // dividend / multiplicand
      data2_o  <= data2_i;           // divisor / multiplier
    end
  end

endmodule

`default_nettype wire

// ==== cplx_mult.sv ====
// complex lane multiplier
// full double-width product, operands read as signed or unsigned
// depending on the select; one shared array for both kinds
`timescale 1ns/10ps
`default_nettype none

module cplx_mult (
  input  logic [cplx_pkg::SIZE_DATA-1:0] a_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0] b_i,
  input  logic                           signed_i,
  output cplx_pkg::prod_word_t           prod_o
);

  import cplx_pkg::*;

  // one extra bit carries the sign, zero for unsigned operands
  logic signed [SIZE_DATA:0]     a_ext;
  logic signed [SIZE_DATA:0]     b_ext;
  logic signed [2*SIZE_DATA-1:0] prod_full;

  // ========================================
  // operand extension
  // ========================================
  assign a_ext = {signed_i & a_i[SIZE_DATA-1], a_i};  // sign or zero extend
  assign b_ext = {signed_i & b_i[SIZE_DATA-1], b_i};

  // ========================================
  // product
  // ========================================
  // 33x33 signed multiply covers both cases, result fits in 64 bits
  assign prod_full = a_ext * b_ext;  // truncated to the double word

  always_comb begin
    prod_o      = '0;
    prod_o.full = prod_full;         // alu picks hi or lo from the union
  end

endmodule

`default_nettype wire

// ==== cplx_div.sv ====
// complex lane divider
// truncating quotient and dividend-signed remainder, with fixed answers
// for a zero divisor and for most-negative / minus one
`timescale 1ns/10ps
`default_nettype none

module cplx_div (
  input  logic [cplx_pkg::SIZE_DATA-1:0] a_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0] b_i,
  input  logic                           signed_i,
  output logic [cplx_pkg::SIZE_DATA-1:0] quot_o,
  output logic [cplx_pkg::SIZE_DATA-1:0] rem_o
);

  import cplx_pkg::*;

  logic                 a_neg;     // dividend negative, signed mode only
  logic                 b_neg;     // divisor negative, signed mode only
  logic                 div_zero;  // divisor is zero
  logic                 div_ovf;   // most-negative / -1
  logic [SIZE_DATA-1:0] a_mag;     // dividend magnitude
  logic [SIZE_DATA-1:0] b_mag;     // divisor magnitude
  logic [SIZE_DATA-1:0] b_safe;    // divisor kept nonzero for the array
  logic [SIZE_DATA-1:0] q_mag;     // unsigned quotient of magnitudes
  logic [SIZE_DATA-1:0] r_mag;     // unsigned remainder of magnitudes

  // ========================================
  // special case detect
  // ========================================
  assign div_zero = (b_i == '0);
  assign div_ovf  = signed_i &&
                    (a_i == {1'b1, {(SIZE_DATA-1){1'b0}}}) &&  // most negative
                    (b_i == '1);                               // minus one

  // ========================================
  // magnitude divide
  // ========================================
  assign a_neg = signed_i & a_i[SIZE_DATA-1];
  assign b_neg = signed_i & b_i[SIZE_DATA-1];

  assign a_mag = a_neg ? (~a_i + 1'b1) : a_i;  // two's complement negate
  assign b_mag = b_neg ? (~b_i + 1'b1) : b_i;

  // keep the array away from divide by zero, its answer is overridden
  assign b_safe = div_zero ? {{(SIZE_DATA-1){1'b0}}, 1'b1} : b_mag;

  assign q_mag = a_mag / b_safe;
  assign r_mag = a_mag % b_safe;

  // ========================================
  // sign fix-up and overrides
  // ========================================
  always_comb begin
    if (div_zero) begin
      quot_o = '1;                   // all ones quotient
      rem_o  = a_i;                  // remainder is the dividend
    end else if (div_ovf) begin
      quot_o = a_i;                  // wraps back to most negative
      rem_o  = '0;
    end else begin
      // quotient negative when signs differ, truncates toward zero
      quot_o = (a_neg ^ b_neg) ? (~q_mag + 1'b1) : q_mag;
      // remainder follows the dividend
      rem_o  = a_neg ? (~r_mag + 1'b1) : r_mag;
    end
  end

endmodule

`default_nettype wire

// ==== complex_alu.sv ====
// complex alu
// decodes mul/div opcodes, drives the multiplier and divider, picks
// the requested half and forms the execution flags
`timescale 1ns/10ps
`default_nettype none

module complex_alu (
  input  logic                             valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]    tag_i,
  input  logic [cplx_pkg::SIZE_OPCODE-1:0] opcode_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data1_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data2_i,
  output logic                             valid_o,
  output logic [cplx_pkg::SIZE_TAG-1:0]    tag_o,
  output logic [cplx_pkg::SIZE_DATA-1:0]   result_o,
  output logic [cplx_pkg::SIZE_FLAGS-1:0]  flags_o
);

  import cplx_pkg::*;

  logic                  use_signed;   // signed operand interpretation
  logic                  sel_prod_lo;  // result is product low word
  logic                  sel_prod_hi;  // result is product high word
  logic                  sel_quot;     // result is quotient
  logic                  sel_rem;      // result is remainder
  prod_word_t            prod;
  logic [SIZE_DATA-1:0]  quot;
  logic [SIZE_DATA-1:0]  rem;
  logic [SIZE_FLAGS-1:0] flags;

  // strobe and tag ride along untouched
  assign valid_o = valid_i;
  assign tag_o   = tag_i;

  // ========================================
  // opcode decode
  // ========================================
  always_comb begin
    use_signed  = 1'b0;
    sel_prod_lo = 1'b0;
    sel_prod_hi = 1'b0;
    sel_quot    = 1'b0;
    sel_rem     = 1'b0;
    flags       = '0;                // unknown opcode, not executed
    case (opcode_i)
      MULT_L:  begin use_signed = 1'b1; sel_prod_lo = 1'b1; flags = FLAGS_MD_LO; end
      MULT_H:  begin use_signed = 1'b1; sel_prod_hi = 1'b1; flags = FLAGS_MD_HI; end
      MULTU_L: begin sel_prod_lo = 1'b1; flags = FLAGS_MD_LO; end
      MULTU_H: begin sel_prod_hi = 1'b1; flags = FLAGS_MD_HI; end
      DIV_L:   begin use_signed = 1'b1; sel_quot = 1'b1; flags = FLAGS_MD_LO; end
      DIV_H:   begin use_signed = 1'b1; sel_rem = 1'b1; flags = FLAGS_MD_HI; end
      DIVU_L:  begin sel_quot = 1'b1; flags = FLAGS_MD_LO; end
      DIVU_H:  begin sel_rem = 1'b1; flags = FLAGS_MD_HI; end
      SYSCALL: begin flags = FLAGS_SYSCALL; end  // result stays zero
      default: begin end
    endcase
    flags[FLG_MISPREDICT] = 1'b0;    // no branch resolution in this lane
    flags[FLG_BRANCH]     = 1'b0;
  end

  assign flags_o = flags;

  // ========================================
  // datapath
  // ========================================
  cplx_mult cplx_mult_i (
    .a_i      (data1_i),
    .b_i      (data2_i),
    .signed_i (use_signed),
    .prod_o   (prod)
  );

  cplx_div cplx_div_i (
    .a_i      (data1_i),
    .b_i      (data2_i),
    .signed_i (use_signed),
    .quot_o   (quot),
    .rem_o    (rem)
  );

  // selects are one-hot or all clear, and-or merge
  assign result_o = ({SIZE_DATA{sel_prod_lo}} & prod.half.lo) |
                    ({SIZE_DATA{sel_prod_hi}} & prod.half.hi) |
                    ({SIZE_DATA{sel_quot}}    & quot)         |
                    ({SIZE_DATA{sel_rem}}     & rem);          // zero otherwise

endmodule

`default_nettype wire

// ==== cplx_writeback.sv ====
// complex lane writeback register
// registers the alu output each cycle; flags drop to zero in empty slots
`timescale 1ns/10ps
`default_nettype none

module cplx_writeback (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]   tag_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]  result_i,
  input  logic [cplx_pkg::SIZE_FLAGS-1:0] flags_i,
  output logic                            valid_o,
  output logic [cplx_pkg::SIZE_TAG-1:0]   tag_o,
  output logic [cplx_pkg::SIZE_DATA-1:0]  result_o,
  output logic [cplx_pkg::SIZE_FLAGS-1:0] flags_o
);

  // ========================================
  // control, strobe and flags
  // ========================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      flags_o <= '0;                          // nothing executed yet
    end else begin
      valid_o <= valid_i;
      flags_o <= valid_i ? flags_i : '0;      // no stale executed bits
    end
  end

  // ========================================
  // payload
  // ========================================
  always_ff @(posedge clk_i) begin
    tag_o    <= tag_i;                        // qualified by valid_o
    result_o <= result_i;
  end

endmodule

`default_nettype wire

// ==== cplx_lane_top.sv ====
// complex-integer execution lane
// issue register, combinational complex alu and writeback register;
// fixed two-cycle latency, one instruction per cycle
`timescale 1ns/10ps
`default_nettype none

module cplx_lane_top (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]    tag_i,
  input  logic [cplx_pkg::SIZE_OPCODE-1:0] opcode_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data1_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   data2_i,
  output logic                             valid_o,
  output logic [cplx_pkg::SIZE_TAG-1:0]    tag_o,
  output logic [cplx_pkg::SIZE_DATA-1:0]   result_o,
  output logic [cplx_pkg::SIZE_FLAGS-1:0]  flags_o
);

  import cplx_pkg::*;

  // issue stage
  logic                   iss_valid;
  logic [SIZE_TAG-1:0]    iss_tag;
  logic [SIZE_OPCODE-1:0] iss_opcode;
  logic [SIZE_DATA-1:0]   iss_data1;
  logic [SIZE_DATA-1:0]   iss_data2;
  // alu output, combinational
  logic                   alu_valid;
  logic [SIZE_TAG-1:0]    alu_tag;
  logic [SIZE_DATA-1:0]   alu_result;
  logic [SIZE_FLAGS-1:0]  alu_flags;

  cplx_issue_reg cplx_issue_reg_i (
    .clk_i, .arst_n_i, .valid_i, .tag_i, .opcode_i, .data1_i, .data2_i,
    .valid_o (iss_valid), .tag_o (iss_tag), .opcode_o (iss_opcode),
    .data1_o (iss_data1), .data2_o (iss_data2)
  );

  complex_alu complex_alu_i (
    .valid_i  (iss_valid), .tag_i   (iss_tag), .opcode_i (iss_opcode),
    .data1_i  (iss_data1), .data2_i (iss_data2),
    .valid_o  (alu_valid), .tag_o   (alu_tag),
    .result_o (alu_result), .flags_o (alu_flags)
  );

  cplx_writeback cplx_writeback_i (
    .clk_i, .arst_n_i,
    .valid_i  (alu_valid), .tag_i (alu_tag),
    .result_i (alu_result), .flags_i (alu_flags),
    .valid_o, .tag_o, .result_o, .flags_o
  );

endmodule

`default_nettype wire

// ==== cplx_lane_chk.sv ====
// complex lane timing assertions
// issue-to-writeback latency, idle flags and known results at the top level
`timescale 1ns/10ps
`default_nettype none

module cplx_lane_chk (
  input logic                            clk_i,
  input logic                            arst_n_i,
  input logic                            valid_i,
  input logic                            out_valid_i,
  input logic [cplx_pkg::SIZE_DATA-1:0]  out_result_i,
  input logic [cplx_pkg::SIZE_FLAGS-1:0] out_flags_i
);

  // exactly two edges from issue to writeback
  latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> ##2 out_valid_i)
    else $error("valid_o did not follow valid_i by two cycles");

  // empty slots never carry executed bits
  idle_flags_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !out_valid_i |-> (out_flags_i == '0))
    else $error("flags_o not zero while valid_o is low");

  known_result_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i |-> !$isunknown(out_result_i))
    else $error("result_o has unknown bits while valid_o is high");

endmodule

bind cplx_lane_top cplx_lane_chk cplx_lane_chk_i (
  .clk_i, .arst_n_i, .valid_i,
  .out_valid_i (valid_o), .out_result_i (result_o), .out_flags_i (flags_o)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and reset
// 10 ns clock, reset held low over the first two rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;                 // in reset from time zero
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;                 // release away from the rising edge
  end

  always #5 clk_o = ~clk_o;          // 10 ns period

endmodule

`default_nettype wire

// ==== tb_cplx_monitor.sv ====
// complex lane checker
// models each issued instruction from the input ports, queues the
// expected writeback and compares it at the output ports
`timescale 1ns/10ps
`default_nettype none

module tb_cplx_monitor (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             in_valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]    in_tag_i,
  input  logic [cplx_pkg::SIZE_OPCODE-1:0] in_opcode_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   in_data1_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   in_data2_i,
  input  logic                             out_valid_i,
  input  logic [cplx_pkg::SIZE_TAG-1:0]    out_tag_i,
  input  logic [cplx_pkg::SIZE_DATA-1:0]   out_result_i,
  input  logic [cplx_pkg::SIZE_FLAGS-1:0]  out_flags_i,
  input  int                               test_id_i,
  input  logic                             done_i,
  output int                               err_cnt_o,
  output int                               chk_cnt_o,
  output int                               pending_o
);

  import cplx_pkg::*;

  typedef struct packed {
    logic [SIZE_TAG-1:0]   tag;
    logic [SIZE_DATA-1:0]  result;
    logic [SIZE_FLAGS-1:0] flags;
    logic [31:0]           cyc;      // edge where the instruction was issued
  } expect_t;

  string   names [5] = '{"reset", "multiply", "divide", "syscall_other", "ordering"};
  expect_t exp_q [$];                // in flight, oldest first
  expect_t head;
  expect_t entry;
  logic [31:0] cyc;                  // rising edges since reset release
  logic        leftover_done;

  // expected {result, flags} straight from the opcode rules
  function automatic logic [SIZE_DATA+SIZE_FLAGS-1:0] model_lane(
    input logic [SIZE_OPCODE-1:0] op,
    input logic [SIZE_DATA-1:0]   a,
    input logic [SIZE_DATA-1:0]   b);
    logic [2*SIZE_DATA-1:0] prod;
    logic [SIZE_DATA-1:0]   q;
    logic [SIZE_DATA-1:0]   r;
    logic [SIZE_FLAGS-1:0]  flg;
    logic                   sgn;
    logic                   lo;
    sgn = (op == MULT_L) || (op == MULT_H) || (op == DIV_L) || (op == DIV_H);
    lo  = (op == MULT_L) || (op == MULTU_L) || (op == DIV_L) || (op == DIVU_L);
    flg = '0;
    flg[FLG_DEST_VALID] = 1'b1;
    flg[FLG_EXECUTED]   = 1'b1;
    flg[FLG_LOW_HALF]   = lo;        // only the _L opcodes
    if (sgn) prod = $signed(a) * $signed(b);  // sign extended to 64 bits
    else     prod = a * b;
    if (b == '0) begin
      q = '1;                        // divide by zero, fixed answer
      r = a;
    end else if (sgn && (a == 32'h8000_0000) && (b == '1)) begin
      q = a;                         // overflow case
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);   // truncates toward zero
      r = $signed(a) % $signed(b);   // sign of the dividend
    end else begin
      q = a / b;
      r = a % b;
    end
    case (op)
      MULT_L, MULT_H, MULTU_L, MULTU_H:
        return {lo ? prod[SIZE_DATA-1:0] : prod[2*SIZE_DATA-1:SIZE_DATA], flg};
      DIV_L, DIV_H, DIVU_L, DIVU_H:
        return {lo ? q : r, flg};
      SYSCALL: begin
        flg = '0;
        flg[FLG_EXECUTED]  = 1'b1;
        flg[FLG_EXCEPTION] = 1'b1;
        return {{SIZE_DATA{1'b0}}, flg};
      end
      default: return '0;            // not executed
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("mismatch test=%s %s expected=%h actual=%h",
               names[test_id_i], what, exp_v, act_v);
      err_cnt_o++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      err_cnt_o     = 0;
      chk_cnt_o     = 0;
      pending_o     = 0;
      cyc           = '0;
      leftover_done = 1'b0;
    end else begin
      // ========================================
      // output side
      // ========================================
      if (out_valid_i && (exp_q.size() == 0)) begin
        $display("error: valid_o high with no instruction in flight");
        err_cnt_o++;
      end else if (out_valid_i) begin
        head = exp_q.pop_front();
        chk_cnt_o++;
        compare("tag", head.tag, out_tag_i);   // also proves issue order
        compare("result", head.result, out_result_i);
        compare("flags", head.flags, out_flags_i);
        if (cyc != head.cyc + 2) begin
          $display("error: tag %0d left after %0d cycles instead of 2",
                   head.tag, cyc - head.cyc);
          err_cnt_o++;
        end
      end else if (out_flags_i !== '0) begin
        $display("error: flags_o not zero while valid_o is low");
        err_cnt_o++;
      end
      // ========================================
      // input side
      // ========================================
      if (in_valid_i) begin
        entry.tag                   = in_tag_i;
        {entry.result, entry.flags} = model_lane(in_opcode_i, in_data1_i, in_data2_i);
        entry.cyc                   = cyc;
        exp_q.push_back(entry);
      end
      if (done_i && !leftover_done) begin
        leftover_done = 1'b1;
        if (exp_q.size() != 0) begin
          $display("error: %0d issued instructions never came out", exp_q.size());
          err_cnt_o++;
        end
      end
      pending_o = exp_q.size();
      cyc       = cyc + 1;
    end
  end

endmodule

`default_nettype wire

// ==== tb_cplx_lane.sv ====
// complex lane testbench top
// random mul/div/syscall streams from an lfsr, per-test report and summary
`timescale 1ns/10ps
`default_nettype none

module tb_cplx_lane;

  import cplx_pkg::*;

  localparam int N_MUL   = 250;
  localparam int N_DIV   = 250;
  localparam int N_MISC  = 100;
  localparam int N_ORDER = 400;
  // about two cycles per instruction with gaps and drains, doubled for margin
  localparam int TIMEOUT_CYCLES = 4 * (N_MUL + N_DIV + N_MISC + N_ORDER);
  localparam int DRAIN_CYCLES   = 4;  // lane latency is two cycles

  logic                   clk;
  logic                   arst_n;
  logic                   valid;
  logic [SIZE_TAG-1:0]    tag;
  logic [SIZE_OPCODE-1:0] opcode;
  logic [SIZE_DATA-1:0]   data1;
  logic [SIZE_DATA-1:0]   data2;
  logic                   out_valid;
  logic [SIZE_TAG-1:0]    out_tag;
  logic [SIZE_DATA-1:0]   out_result;
  logic [SIZE_FLAGS-1:0]  out_flags;
  logic                   done;
  int                     test_id;
  int                     err_cnt;
  int                     chk_cnt;
  int                     pending;
  int                     err_base;
  int                     chk_base;
  int                     cycles = 0;
  logic [31:0]            lfsr_state = 32'd80046;
  logic [SIZE_OPCODE-1:0] md_ops [8] = '{MULT_L, MULT_H, MULTU_L, MULTU_H,
                                         DIV_L, DIV_H, DIVU_L, DIVU_H};

  tb_clk_gen tb_clk_gen_i (.clk_o (clk), .arst_n_o (arst_n));

  cplx_lane_top cplx_lane_top_i (
    .clk_i (clk), .arst_n_i (arst_n), .valid_i (valid), .tag_i (tag),
    .opcode_i (opcode), .data1_i (data1), .data2_i (data2),
    .valid_o (out_valid), .tag_o (out_tag), .result_o (out_result), .flags_o (out_flags)
  );

  tb_cplx_monitor tb_cplx_monitor_i (
    .clk_i (clk), .arst_n_i (arst_n), .in_valid_i (valid), .in_tag_i (tag),
    .in_opcode_i (opcode), .in_data1_i (data1), .in_data2_i (data2),
    .out_valid_i (out_valid), .out_tag_i (out_tag), .out_result_i (out_result),
    .out_flags_i (out_flags), .test_id_i (test_id), .done_i (done),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt), .pending_o (pending)
  );

  // right-shift galois lfsr, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};  // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // corner values often enough to hit the divide special cases
  task automatic pick_operand(output logic [31:0] v);
    logic [31:0] sel;
    take_bits(3, sel);
    case (sel[2:0])
      3'd0:    v = '0;
      3'd1:    v = '1;
      3'd2:    v = 32'h8000_0000;
      default: take_bits(32, v);
    endcase
  endtask

  task automatic issue(input logic [SIZE_OPCODE-1:0] op, input logic [31:0] a,
                       input logic [31:0] b);
    @(negedge clk);
    valid  = 1'b1;
    tag    = tag + 1'b1;             // fresh tag per instruction
    opcode = op;
    data1  = a;
    data2  = b;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      valid = 1'b0;
    end
  endtask

  task automatic maybe_gap(input int bits);  // one idle cycle, chance 1 in 2^bits
    logic [31:0] r;
    take_bits(bits, r);
    if (r == 0) idle(1);
  endtask

  task automatic start_test(input int id);
    test_id  = id;
    err_base = err_cnt;
    chk_base = chk_cnt;
  endtask

  // drain the lane, a lost result stays in the monitor queue
  task automatic finish_test();
    int waited;
    waited = 0;
    idle(1);
    while ((pending != 0) && (waited < DRAIN_CYCLES)) begin
      idle(1);
      waited++;
    end
    $display("test %-14s %0d checked, %0d errors", tb_cplx_monitor_i.names[test_id],
             chk_cnt - chk_base, err_cnt - err_base);
  endtask

  // ========================================
  // stimulus
  // ========================================
  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    valid   = 1'b0;
    tag     = '0;
    opcode  = '0;
    data1   = '0;
    data2   = '0;
    done    = 1'b0;
    test_id = 0;
    wait (arst_n === 1'b1);
    start_test(0);                   // lane stays quiet with no input
    idle(8);
    finish_test();
    start_test(1);
    for (int i = 0; i < N_MUL; i++) begin
      take_bits(2, r);
      pick_operand(a);
      pick_operand(b);
      issue(md_ops[r[1:0]], a, b);
      maybe_gap(3);
    end
    finish_test();
    start_test(2);
    for (int i = 0; i < 4; i++) begin
      issue(md_ops[4+i], 32'h8000_0000, '1);     // most negative over minus one
      issue(md_ops[4+i], 32'h1234_5678 ^ i, '0); // zero divisor
    end
    for (int i = 0; i < N_DIV; i++) begin
      take_bits(2, r);
      pick_operand(a);
      pick_operand(b);
      issue(md_ops[4+r[1:0]], a, b);
      maybe_gap(3);
    end
    finish_test();
    start_test(3);
    for (int i = 0; i < N_MISC; i++) begin
      take_bits(9, r);               // top bit picks syscall, rest is an opcode
      pick_operand(a);
      pick_operand(b);
      issue(r[8] ? SYSCALL : r[7:0], a, b);
    end
    finish_test();
    start_test(4);
    for (int i = 0; i < N_ORDER; i++) begin
      take_bits(4, r);
      take_bits(8, b);
      if (r < 8) b = md_ops[r[2:0]];
      else if (r == 8) b = SYSCALL;
      pick_operand(a);
      take_bits(32, r);
      issue(b[7:0], a, r);
      maybe_gap(2);                  // back to back most of the time
    end
    finish_test();
    done = 1'b1;                     // monitor checks for leftovers
    @(posedge clk);
    @(negedge clk);
    $display("summary: %0d results checked, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
cplx_pkg.sv
cplx_issue_reg.sv
cplx_mult.sv
cplx_div.sv
complex_alu.sv
cplx_writeback.sv
cplx_lane_top.sv
cplx_lane_chk.sv
tb_clk_gen.sv
tb_cplx_monitor.sv
tb_cplx_lane.sv
